// File: tb.f
+incdir+logic
logic/rot_geom_pkg.sv
logic/rot_stream_pkg.sv
logic/rotator_ifs.sv
logic/word_packer.sv
logic/load_ctrl.sv
logic/weight_bank.sv
logic/rotation_reader.sv
logic/weight_rotator.sv
tests/weight_rotator_sva.sv
tests/weight_rotator_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := weight_rotator_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/weight_rotator_tb.sv
`timescale 1ns/1ps
`include "rot_defines.svh"

module weight_rotator_tb;

  logic                       aclk;
  logic                       i_rst;
  logic                       i_s_valid;
  logic                       o_s_ready;
  rot_stream_pkg::s_word_t    i_s_data;
  logic                       i_s_last;
  logic                       o_m_valid;
  logic                       i_m_ready;
  rot_stream_pkg::wide_word_t o_m_data;
  logic                       o_m_last;
  rot_stream_pkg::tuser_t     o_m_tuser;

  // reference model queues
  rot_stream_pkg::s_word_t    in_word[$];
  logic                       in_last[$];
  rot_stream_pkg::wide_word_t exp_data[$];
  logic                       exp_last[$];
  rot_stream_pkg::tuser_t     exp_user[$];
  int                         tensor_beats[$];

  rot_geom_pkg::geom_t max_geom;
  int   total_beats;
  int   beats_seen = 0;
  int   data_errs = 0;
  int   flag_errs = 0;
  int   other_errs = 0;
  logic bp_en = 1'b0;
  logic gap_en = 1'b0;

  bind weight_rotator weight_rotator_sva u_sva (
    .aclk      (aclk),
    .i_rst     (i_rst),
    .o_s_ready (o_s_ready),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_tuser (o_m_tuser)
  );

  weight_rotator DUT (
    .aclk      (aclk),
    .i_rst     (i_rst),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_tuser (o_m_tuser)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  function automatic rot_geom_pkg::geom_t rand_geom();
    rot_geom_pkg::geom_t g;
    begin
      // kh stays at 3 or below so kh * cin fits a bank
      g.kh_1     = `ROT_KH_BITS'($urandom_range(2, 0));
      g.cin_1    = `ROT_CIN_BITS'($urandom_range(15, 0));
      g.cols_1   = `ROT_COLS_BITS'($urandom_range(7, 0));
      g.blocks_1 = `ROT_BLOCKS_BITS'($urandom_range(3, 0));
      return g;
    end
  endfunction

  // header, packed weights and the expected replay of one tensor
  task automatic add_tensor(input rot_geom_pkg::geom_t g);
    rot_stream_pkg::wide_word_t words[$];
    rot_stream_pkg::wide_word_t acc;
    rot_stream_pkg::tuser_t     u;
    rot_stream_pkg::s_word_t    w;
    int cols;
    int k;
    int reps;
    begin
      k    = (int'(g.kh_1) + 1) * (int'(g.cin_1) + 1);
      cols = int'(g.cols_1) + 1;
      reps = cols * (int'(g.blocks_1) + 1);
      assert (k <= `ROT_BANK_DEPTH) else begin
        other_errs++;
        $display("generated tensor does not fit one bank");
      end
      in_word.push_back(`ROT_S_WIDTH'(g));
      in_last.push_back(1'b0);
      for (int i = 0; i < k; i++) begin
        for (int j = 0; j < `ROT_PACK_RATIO; j++) begin
          w = $urandom();
          in_word.push_back(w);
          in_last.push_back(i == k - 1 && j == `ROT_PACK_RATIO - 1);
          acc[`ROT_S_WIDTH*j +: `ROT_S_WIDTH] = w;
        end
        words.push_back(acc);
      end
      for (int r = 0; r < reps; r++) begin
        for (int i = 0; i < k; i++) begin
          exp_data.push_back(words[i]);
          exp_last.push_back(r == reps - 1 && i == k - 1);
          u.is_cin_last     = (i == k - 1);
          u.is_top_block    = (r < cols);
          u.is_bottom_block = (r >= reps - cols);
          exp_user.push_back(u);
        end
      end
      tensor_beats.push_back(k * reps);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the handshake
  task automatic send_beat(input rot_stream_pkg::s_word_t w, input logic last);
    begin
      while (gap_en && ($urandom_range(3, 0) == 0)) begin
        i_s_valid = 1'b0;
        @(negedge aclk);
      end
      i_s_valid = 1'b1;
      i_s_data  = w;
      i_s_last  = last;
      while (!o_s_ready) @(negedge aclk);
      @(negedge aclk);
    end
  endtask

  task automatic send_tensor();
    rot_stream_pkg::s_word_t w;
    logic l;
    begin
      do begin
        w = in_word.pop_front();
        l = in_last.pop_front();
        send_beat(w, l);
      end while (!l);
      i_s_valid = 1'b0;
    end
  endtask

  task automatic check_beat();
    rot_stream_pkg::wide_word_t want_data;
    rot_stream_pkg::tuser_t     want_user;
    logic                       want_last;
    begin
      beats_seen++;
      assert (exp_data.size() != 0) else begin
        other_errs++;
        $display("output beat arrived after every expected beat was seen");
      end
      if (exp_data.size() != 0) begin
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        want_user = exp_user.pop_front();
        assert (o_m_data == want_data) else begin
          data_errs++;
          $display("error o_m_data got %h expected %h", o_m_data, want_data);
        end
        assert (o_m_last == want_last) else begin
          flag_errs++;
          $display("error o_m_last got %h expected %h", o_m_last, want_last);
        end
        assert (o_m_tuser == want_user) else begin
          flag_errs++;
          $display("error o_m_tuser got %h expected %h", o_m_tuser, want_user);
        end
      end
    end
  endtask

  task automatic watchdog(input int cycles);
    begin
      repeat (cycles) @(posedge aclk);
      $display("timeout after %0d cycles with %0d of %0d beats seen", cycles, beats_seen,
               total_beats);
      $display("tests failed");
      $finish;
    end
  endtask

  // output side, ready and beat check on the falling edge
  initial begin
    forever begin
      @(negedge aclk);
      if (!i_rst) begin
        i_m_ready = bp_en ? ($urandom_range(3, 0) != 0) : 1'b1;
        if (o_m_valid && i_m_ready) begin
          check_beat();
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h186a));
    i_rst     = 1'b1;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b0;
    max_geom.kh_1     = 2'd2;
    max_geom.cin_1    = '1;
    max_geom.cols_1   = '1;
    max_geom.blocks_1 = '1;
    add_tensor(rand_geom());
    add_tensor('0);
    add_tensor(max_geom);
    repeat (4) add_tensor(rand_geom());
    total_beats = exp_data.size();
    fork
      watchdog(total_beats * 40 + 500);
    join_none
    repeat (2) @(negedge aclk);
    i_rst = 1'b0;
    // first tensor alone with a free-running sink
    send_tensor();
    while (beats_seen < tensor_beats[0]) @(negedge aclk);
    bp_en  = 1'b1;
    gap_en = 1'b1;
    while (in_word.size() != 0) send_tensor();
    while (beats_seen < total_beats) @(negedge aclk);
    repeat (20) @(negedge aclk);
    $display("beats %0d, data errors %0d, flag errors %0d, other errors %0d, sva failures %0d",
             beats_seen, data_errs, flag_errs, other_errs, DUT.u_sva.fail_cnt);
    if (data_errs + flag_errs + other_errs == 0 && DUT.u_sva.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tests/weight_rotator_sva.sv
`timescale 1ns/1ps

module weight_rotator_sva (
  input logic                       aclk,
  input logic                       i_rst,
  input logic                       o_s_ready,
  input logic                       o_m_valid,
  input logic                       i_m_ready,
  input rot_stream_pkg::wide_word_t o_m_data,
  input logic                       o_m_last,
  input rot_stream_pkg::tuser_t     o_m_tuser
);

  int unsigned fail_cnt = 0;

  // both streams quiet right after a reset cycle
  a_reset_quiet: assert property (@(posedge aclk) i_rst |=> !o_m_valid && !o_s_ready)
    else begin
      fail_cnt++;
      $error("stream valid or ready high one cycle after reset");
    end

  // a stalled beat must not change under back-pressure
  a_stall_hold: assert property (@(posedge aclk) disable iff (i_rst)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) && $stable(o_m_last)
      && $stable(o_m_tuser))
    else begin
      fail_cnt++;
      $error("output beat changed while stalled");
    end

  // tlast only ever rides on a valid beat
  a_last_valid: assert property (@(posedge aclk) disable iff (i_rst)
    o_m_last |-> o_m_valid)
    else begin
      fail_cnt++;
      $error("o_m_last high while o_m_valid is low");
    end

endmodule

// File: logic/weight_rotator.sv
`timescale 1ns/1ps

module weight_rotator (
  input  logic                       aclk,
  input  logic                       i_rst,
  input  logic                       i_s_valid,
  output logic                       o_s_ready,
  input  rot_stream_pkg::s_word_t    i_s_data,
  input  logic                       i_s_last,
  output logic                       o_m_valid,
  input  logic                       i_m_ready,
  output rot_stream_pkg::wide_word_t o_m_data,
  output logic                       o_m_last,
  output rot_stream_pkg::tuser_t     o_m_tuser
);

  logic pk_valid;
  logic pk_ready;

  packed_if  pk ();
  bank_wr_if wr0 ();
  bank_wr_if wr1 ();
  bank_rd_if rd0 ();
  bank_rd_if rd1 ();

  word_packer u_packer (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (pk_valid),
    .o_ready (pk_ready),
    .i_data  (i_s_data),
    .i_last  (i_s_last),
    .o_out   (pk.source)
  );

  load_ctrl u_load (
    .aclk       (aclk),
    .i_rst      (i_rst),
    .i_s_valid  (i_s_valid),
    .o_s_ready  (o_s_ready),
    .i_s_data   (i_s_data),
    .i_s_last   (i_s_last),
    .o_pk_valid (pk_valid),
    .i_pk_ready (pk_ready),
    .i_pk       (pk.sink),
    .o_bank0    (wr0.writer),
    .o_bank1    (wr1.writer)
  );

  // ping-pong pair
  weight_bank u_bank0 (
    .aclk  (aclk),
    .i_rst (i_rst),
    .i_wr  (wr0.bank),
    .o_rd  (rd0.bank)
  );

  weight_bank u_bank1 (
    .aclk  (aclk),
    .i_rst (i_rst),
    .i_wr  (wr1.bank),
    .o_rd  (rd1.bank)
  );

  rotation_reader u_reader (
    .aclk      (aclk),
    .i_rst     (i_rst),
    .i_bank0   (rd0.reader),
    .i_bank1   (rd1.reader),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_tuser (o_m_tuser)
  );

endmodule

// File: logic/rotation_reader.sv
`timescale 1ns/1ps
`include "rot_defines.svh"

module rotation_reader (
  input  logic                       aclk,
  input  logic                       i_rst,
  bank_rd_if.reader                  i_bank0,
  bank_rd_if.reader                  i_bank1,
  output logic                       o_m_valid,
  input  logic                       i_m_ready,
  output rot_stream_pkg::wide_word_t o_m_data,
  output logic                       o_m_last,
  output rot_stream_pkg::tuser_t     o_m_tuser
);

  // counters 0..3 are kh, cin, cols and blocks from the innermost out
  localparam int NC   = 4;
  localparam int CW_A = (`ROT_KH_BITS > `ROT_CIN_BITS) ? `ROT_KH_BITS : `ROT_CIN_BITS;
  localparam int CW_B = (`ROT_COLS_BITS > `ROT_BLOCKS_BITS) ? `ROT_COLS_BITS : `ROT_BLOCKS_BITS;
  localparam int CW   = (CW_A > CW_B) ? CW_A : CW_B;

  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} r_state_t;

  r_state_t            state;
  r_state_t            state_next;
  logic                rd_sel;
  logic                bank_valid;
  logic                bank_loaded;
  logic                beat;
  logic                done;
  rot_geom_pkg::geom_t geom;
  logic [CW-1:0]       lim [NC];
  logic [CW-1:0]       cnt [NC];
  logic                last_q [NC];
  logic                step [NC];

  // read bank mux
  assign bank_valid  = rd_sel ? i_bank1.rvalid : i_bank0.rvalid;
  assign bank_loaded = rd_sel ? i_bank1.loaded : i_bank0.loaded;
  assign geom        = rd_sel ? i_bank1.geom : i_bank0.geom;
  assign o_m_data    = rd_sel ? i_bank1.rdata : i_bank0.rdata;

  assign o_m_valid = (state == R_READ) & bank_valid;
  assign beat      = o_m_valid & i_m_ready;
  assign o_m_last  = o_m_valid & last_q[0] & last_q[1] & last_q[2] & last_q[3];
  assign done      = beat & o_m_last;

  assign i_bank0.rd_en        = (state == R_READ) & ~rd_sel & i_m_ready;
  assign i_bank1.rd_en        = (state == R_READ) & rd_sel & i_m_ready;
  assign i_bank0.release_bank = (state == R_SWITCH) & ~rd_sel;
  assign i_bank1.release_bank = (state == R_SWITCH) & rd_sel;

  assign o_m_tuser.is_cin_last     = last_q[0] & last_q[1];
  assign o_m_tuser.is_top_block    = (cnt[3] == lim[3]);
  assign o_m_tuser.is_bottom_block = last_q[3];

  always_comb begin
    state_next = state;
    case (state)
      R_IDLE:  if (bank_loaded) state_next = R_READ;
      R_READ:  if (done) state_next = R_SWITCH;
      default: state_next = R_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state  <= R_IDLE;
      rd_sel <= 1'b0;
    end else begin
      state <= state_next;
      if (state == R_SWITCH) begin
        rd_sel <= ~rd_sel;
      end
    end
  end

  assign lim[0] = CW'(geom.kh_1);
  assign lim[1] = CW'(geom.cin_1);
  assign lim[2] = CW'(geom.cols_1);
  assign lim[3] = CW'(geom.blocks_1);

  // each counter steps when all inner ones wrap
  assign step[0] = beat;
  for (genvar i = 1; i < NC; i++) begin : g_step
    assign step[i] = step[i-1] & last_q[i-1];
  end

  for (genvar i = 0; i < NC; i++) begin : g_cnt
    always_ff @(posedge aclk) begin
      if (i_rst) begin
        cnt[i]    <= '0;
        last_q[i] <= 1'b0;
      end else if (state == R_IDLE || (step[i] && last_q[i])) begin
        // reload from the read bank geometry
        cnt[i]    <= lim[i];
        last_q[i] <= (lim[i] == '0);
      end else if (step[i]) begin
        cnt[i]    <= cnt[i] - 1;
        last_q[i] <= (cnt[i] == 1);
      end
    end
  end

endmodule

// File: logic/weight_bank.sv
`timescale 1ns/1ps
`include "rot_defines.svh"

module weight_bank (
  input logic     aclk,
  input logic     i_rst,
  bank_wr_if.bank i_wr,
  bank_rd_if.bank o_rd
);

  rot_stream_pkg::wide_word_t mem [`ROT_BANK_DEPTH];
  rot_stream_pkg::wide_word_t mem_rd;
  rot_stream_pkg::wide_word_t q_head;
  rot_stream_pkg::wide_word_t q_tail;
  rot_geom_pkg::geom_t        geom_q;
  rot_geom_pkg::addr_t        waddr;
  rot_geom_pkg::addr_t        rptr;
  rot_geom_pkg::addr_t        rd_max;
  rot_geom_pkg::addr_t        kh_n;
  rot_geom_pkg::addr_t        cin_n;
  logic [1:0]                 q_cnt;
  logic                       reading;
  logic                       loaded;
  logic                       push;
  logic                       pop;

  // one rotation pass covers kh * cin words
  assign kh_n   = rot_geom_pkg::addr_t'(geom_q.kh_1) + 1;
  assign cin_n  = rot_geom_pkg::addr_t'(geom_q.cin_1) + 1;
  assign rd_max = kh_n * cin_n - 1;

  assign mem_rd = mem[rptr];
  assign pop    = o_rd.rd_en & o_rd.rvalid;
  // keep the queue topped up so rvalid never drops
  assign push   = reading & ((q_cnt != 2'd2) | pop);

  assign o_rd.rdata  = q_head;
  assign o_rd.rvalid = (q_cnt != 2'd0);
  assign o_rd.geom   = geom_q;
  assign o_rd.loaded = loaded;
  assign i_wr.loaded = loaded;

  always_ff @(posedge aclk) begin
    if (i_wr.wen) begin
      mem[waddr] <= i_wr.wdata;
    end
    if (i_wr.start) begin
      geom_q <= i_wr.geom;
    end
  end

  // two-entry prefetch queue, head is the word on offer
  always_ff @(posedge aclk) begin
    if (pop) begin
      q_head <= (q_cnt == 2'd2) ? q_tail : mem_rd;
      q_tail <= mem_rd;
    end else if (push) begin
      if (q_cnt == 2'd0) begin
        q_head <= mem_rd;
      end else begin
        q_tail <= mem_rd;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst || i_wr.start) begin
      waddr   <= '0;
      rptr    <= '0;
      reading <= 1'b0;
      loaded  <= 1'b0;
      q_cnt   <= 2'd0;
    end else begin
      if (i_wr.wen) begin
        waddr <= waddr + 1;
      end
      if (o_rd.release_bank) begin
        rptr    <= '0;
        reading <= 1'b0;
        loaded  <= 1'b0;
        q_cnt   <= 2'd0;
      end else begin
        if (i_wr.wen && i_wr.wlast) begin
          reading <= 1'b1;
        end
        if (push) begin
          rptr   <= (rptr == rd_max) ? '0 : rptr + 1;
          // first fetched word makes the bank visible to the reader
          loaded <= 1'b1;
        end
        case ({push, pop})
          2'b10:   q_cnt <= q_cnt + 2'd1;
          2'b01:   q_cnt <= q_cnt - 2'd1;
          default: q_cnt <= q_cnt;
        endcase
      end
    end
  end

endmodule

// File: logic/load_ctrl.sv
`timescale 1ns/1ps

module load_ctrl (
  input  logic                    aclk,
  input  logic                    i_rst,
  input  logic                    i_s_valid,
  output logic                    o_s_ready,
  input  rot_stream_pkg::s_word_t i_s_data,
  input  logic                    i_s_last,
  output logic                    o_pk_valid,
  input  logic                    i_pk_ready,
  packed_if.sink                  i_pk,
  bank_wr_if.writer               o_bank0,
  bank_wr_if.writer               o_bank1
);

  typedef enum logic [1:0] {W_IDLE, W_HEADER, W_WRITE, W_SWITCH} w_state_t;

  w_state_t            state;
  w_state_t            state_next;
  logic                wr_sel;
  logic                bypass;
  logic                s_hs;
  logic                hdr_hs;
  logic                wr_beat;
  logic                sel_loaded;
  rot_geom_pkg::geom_t hdr_geom;

  // header beat goes to the geometry capture, the rest to the packer
  assign o_s_ready  = bypass ? i_pk_ready : (state == W_HEADER);
  assign o_pk_valid = bypass & i_s_valid;
  assign s_hs       = i_s_valid & o_s_ready;
  assign hdr_hs     = s_hs & ~bypass;
  assign hdr_geom   = i_s_data[$bits(rot_geom_pkg::geom_t)-1:0];

  assign i_pk.ready = (state == W_WRITE);
  assign wr_beat    = i_pk.valid & i_pk.ready;
  assign sel_loaded = wr_sel ? o_bank1.loaded : o_bank0.loaded;

  assign o_bank0.start = hdr_hs & ~wr_sel;
  assign o_bank0.geom  = hdr_geom;
  assign o_bank0.wen   = wr_beat & ~wr_sel;
  assign o_bank0.wdata = i_pk.data;
  assign o_bank0.wlast = i_pk.last;

  assign o_bank1.start = hdr_hs & wr_sel;
  assign o_bank1.geom  = hdr_geom;
  assign o_bank1.wen   = wr_beat & wr_sel;
  assign o_bank1.wdata = i_pk.data;
  assign o_bank1.wlast = i_pk.last;

  always_comb begin
    state_next = state;
    case (state)
      // wait for the reader to let go of this bank
      W_IDLE:   if (!sel_loaded) state_next = W_HEADER;
      W_HEADER: if (hdr_hs) state_next = W_WRITE;
      W_WRITE:  if (wr_beat && i_pk.last) state_next = W_SWITCH;
      default:  state_next = W_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state  <= W_IDLE;
      wr_sel <= 1'b0;
      bypass <= 1'b0;
    end else begin
      state <= state_next;
      if (state == W_SWITCH) begin
        wr_sel <= ~wr_sel;
      end
      if (hdr_hs) begin
        bypass <= 1'b1;
      end else if (bypass && s_hs && i_s_last) begin
        bypass <= 1'b0;
      end
    end
  end

endmodule

// File: logic/word_packer.sv
`timescale 1ns/1ps
`include "rot_defines.svh"

module word_packer (
  input  logic                    aclk,
  input  logic                    i_rst,
  input  logic                    i_valid,
  output logic                    o_ready,
  input  rot_stream_pkg::s_word_t i_data,
  input  logic                    i_last,
  packed_if.source                o_out
);

  localparam int CNT_BITS = $clog2(`ROT_PACK_RATIO);
  localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`ROT_PACK_RATIO - 1);

  rot_stream_pkg::wide_word_t asm_q;
  logic [CNT_BITS-1:0]        cnt;
  logic                       full;
  logic                       last_q;
  logic                       in_hs;
  logic                       out_hs;

  // input stalls while a finished word waits downstream
  assign o_ready = ~full;
  assign in_hs   = i_valid & o_ready;
  assign out_hs  = o_out.valid & o_out.ready;

  assign o_out.valid = full;
  assign o_out.data  = asm_q;
  assign o_out.last  = last_q;

  // shift right so the first word ends up in the low lane
  always_ff @(posedge aclk) begin
    if (in_hs) begin
      asm_q  <= {i_data, asm_q[`ROT_M_WIDTH-1:`ROT_S_WIDTH]};
      last_q <= i_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      cnt  <= '0;
      full <= 1'b0;
    end else if (in_hs) begin
      cnt <= (cnt == CNT_LAST) ? '0 : cnt + 1;
      // fourth word completes the packed beat
      if (cnt == CNT_LAST) begin
        full <= 1'b1;
      end
    end else if (out_hs) begin
      full <= 1'b0;
    end
  end

endmodule

// File: logic/rotator_ifs.sv
`timescale 1ns/1ps

// wide words from the packer into the write controller
interface packed_if;
  logic                       valid;
  logic                       ready;
  rot_stream_pkg::wide_word_t data;
  logic                       last;

  modport source (output valid, output data, output last, input ready);
  modport sink (input valid, input data, input last, output ready);
endinterface

// write side of one bank
interface bank_wr_if;
  logic                       start;
  rot_geom_pkg::geom_t        geom;
  logic                       wen;
  rot_stream_pkg::wide_word_t wdata;
  logic                       wlast;
  logic                       loaded;

  modport writer (output start, geom, wen, wdata, wlast, input loaded);
  modport bank (input start, geom, wen, wdata, wlast, output loaded);
endinterface

// read side of one bank
interface bank_rd_if;
  logic                       rd_en;
  rot_stream_pkg::wide_word_t rdata;
  logic                       rvalid;
  rot_geom_pkg::geom_t        geom;
  logic                       loaded;
  logic                       release_bank;

  modport bank (input rd_en, release_bank, output rdata, rvalid, geom, loaded);
  modport reader (output rd_en, release_bank, input rdata, rvalid, geom, loaded);
endinterface

// File: logic/rot_stream_pkg.sv
`include "rot_defines.svh"

package rot_stream_pkg;

  // narrow input beat
  typedef logic [`ROT_S_WIDTH-1:0] s_word_t;

  // packed beat, input word 0 sits in the lowest lane
  typedef logic [`ROT_M_WIDTH-1:0] wide_word_t;

  // output sideband
  typedef struct packed {
    logic is_cin_last;
    logic is_top_block;
    logic is_bottom_block;
  } tuser_t;

endpackage

// File: logic/rot_geom_pkg.sv
`include "rot_defines.svh"

package rot_geom_pkg;

  // low 11 bits of the header beat, kh_1 in the lsbs
  typedef struct packed {
    logic [`ROT_BLOCKS_BITS-1:0] blocks_1;
    logic [`ROT_COLS_BITS-1:0]   cols_1;
    logic [`ROT_CIN_BITS-1:0]    cin_1;
    logic [`ROT_KH_BITS-1:0]     kh_1;
  } geom_t;

  // word address inside one bank
  typedef logic [`ROT_ADDR_BITS-1:0] addr_t;

endpackage

// File: logic/rot_defines.svh
`ifndef ROT_DEFINES_SVH
`define ROT_DEFINES_SVH

// stream widths
`define ROT_S_WIDTH 32
`define ROT_PACK_RATIO 4
`define ROT_M_WIDTH 128

// header field widths, each field holds (dimension - 1)
`define ROT_KH_BITS 2
`define ROT_CIN_BITS 4
`define ROT_COLS_BITS 3
`define ROT_BLOCKS_BITS 2

// one bank holds kh * cin wide words at most
`define ROT_BANK_DEPTH 48
`define ROT_ADDR_BITS 6

`endif
